// File: verilog/frame_pkg.sv
// ##############################
// Ethernet/ARP/IPv4 wire format
// Offsets, protocol values, limits
// ##############################
`default_nettype none

package frame_pkg;

	// Preamble and start-of-frame delimiter
	localparam logic [7:0] preamble_octet = 8'h55;
	localparam logic [7:0] sfd_octet = 8'hd5;

	// Idle cycles required ahead of an SFD
	localparam logic [3:0] min_ifg = 4'd10;
	// Frames reaching this octet count are dropped
	localparam logic [10:0] max_frame_len = 11'd1536;

	// Ethertype field and its values
	localparam logic [10:0] eth_type_off = 11'd12;
	localparam logic [15:0] ethertype_ipv4 = 16'h0800;
	localparam logic [15:0] ethertype_arp = 16'h0806;

	// Octet offsets counted from the first octet after the SFD
	localparam logic [10:0] src_mac_first_off = 11'd6;
	localparam logic [10:0] arp_hdr_off = 11'd14;
	localparam logic [10:0] arp_op_end = 11'd21;
	// ARP target protocol address, four octets
	localparam logic [10:0] arp_tpa_off = 11'd38;
	localparam logic [10:0] ip_hdr_off = 11'd14;
	localparam logic [10:0] ip_len_off = 11'd16;
	localparam logic [10:0] ip_ttl_off = 11'd22;
	// IPv4 destination address, four octets
	localparam logic [10:0] ip_dst_off = 11'd30;
	localparam logic [10:0] ip_hdr_end = 11'd34;

	// 14 octets of MAC header plus 4 of FCS
	localparam logic [10:0] eth_overhead = 11'd18;
	// Raw CRC register value after a good FCS, no final inversion
	localparam logic [31:0] crc_residue = 32'hdebb20e3;

	// Configuration memory layout
	localparam logic [3:0] cfg_mac_base = 4'd0;
	localparam logic [3:0] cfg_ip_base = 4'd8;

endpackage

`default_nettype wire

// File: verilog/scan_pkg.sv
// ##############################
// Frame scanner internal types
// ##############################
`default_nettype none

package scan_pkg;

	// Octet position counter width
	localparam int cnt_w = 11;

	// Receive framer states
	typedef enum logic [1:0] {
		idle,
		preamble,
		data,
		drop
	} rx_state_t;

	// Frame category reported in the status summary
	typedef enum logic [1:0] {
		cat_other = 2'd0,
		cat_arp = 2'd1,
		cat_ipv4 = 2'd2
	} category_t;

endpackage

`default_nettype wire

// File: verilog/rx_framer.sv
// ##############################
// Receive framer
// Preamble/SFD check, gap and drop
// ##############################
`timescale 1ns/1ps
`default_nettype none

module rx_framer (
	input  logic       clk,
	input  logic       rst,
	input  logic [7:0] eth_in,
	input  logic       eth_in_s,
	input  logic       eth_pkt,
	input  logic       ifg_ok,
	input  logic       too_long,
	output logic       in_data
);

	scan_pkg::rx_state_t state;
	logic strobe;

	// Only octets inside the envelope count
	assign strobe = eth_in_s & eth_pkt;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= scan_pkg::idle;
		end else begin
			case (state)
				scan_pkg::idle: begin
					// First octet decides between preamble and junk
					if (strobe) begin
						if (eth_in == frame_pkg::preamble_octet)
							state <= scan_pkg::preamble;
						else
							state <= scan_pkg::drop;
					end
				end
				scan_pkg::preamble: begin
					if (strobe && eth_in == frame_pkg::sfd_octet) begin
						// SFD only accepted after a full gap
						state <= ifg_ok ? scan_pkg::data : scan_pkg::drop;
					end else if (strobe && eth_in != frame_pkg::preamble_octet) begin
						// Scrambled preamble
						state <= scan_pkg::drop;
					end else if (!eth_pkt) begin
						state <= scan_pkg::idle;
					end
				end
				scan_pkg::data: begin
					if (!eth_pkt)
						state <= scan_pkg::idle;
					else if (too_long)
						state <= scan_pkg::drop;
				end
				scan_pkg::drop: begin
					// Wait out the rest of the frame
					if (!strobe)
						state <= scan_pkg::idle;
				end
				default: state <= scan_pkg::idle;
			endcase
		end
	end

	// Stays high one cycle past the last octet, while eth_pkt is low
	assign in_data = state == scan_pkg::data;

	// Data only ever opens on a strobed SFD seen after a full gap
	assert property (@(posedge clk) disable iff (rst)
		$rose(in_data) |-> $past(ifg_ok && eth_in_s && eth_in == frame_pkg::sfd_octet));

endmodule

`default_nettype wire

// File: verilog/octet_counter.sv
// ##############################
// Octet position and gap timer
// ##############################
`timescale 1ns/1ps
`default_nettype none

module octet_counter (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      in_data,
	output logic [scan_pkg::cnt_w-1:0] pos,
	output logic                      ifg_ok,
	output logic                      too_long
);

	logic [3:0] gap;

	// Position of the octet now on eth_in, zero outside a frame
	always_ff @(posedge clk) begin
		if (rst)
			pos <= '0;
		else if (in_data)
			pos <= pos + 1'b1;
		else
			pos <= '0;
	end

	assign too_long = pos >= frame_pkg::max_frame_len;

	// Gap timer, saturates once the minimum gap is reached
	always_ff @(posedge clk) begin
		if (rst) begin
			// Line is treated as idle out of reset
			gap <= frame_pkg::min_ifg;
		end else if (in_data) begin
			gap <= '0;
		end else if (gap != frame_pkg::min_ifg) begin
			gap <= gap + 1'b1;
		end
	end

	assign ifg_ok = gap >= frame_pkg::min_ifg;

endmodule

`default_nettype wire

// File: verilog/addr_match.sv
// ##############################
// Address match against config
// Dest MAC, ARP target IP, IP dest
// ##############################
`timescale 1ns/1ps
`default_nettype none

module addr_match (
	input  logic                      clk,
	input  logic                      rst,
	input  logic [scan_pkg::cnt_w-1:0] pos,
	input  logic [7:0]                data_d1,
	input  logic [7:0]                cfg_d,
	output logic [3:0]                cfg_a,
	output logic                      pass_ethmac,
	output logic                      pass_ipdst,
	output logic                      pass_arptpa
);

	logic [scan_pkg::cnt_w-1:0] tpa_idx;
	logic [scan_pkg::cnt_w-1:0] ip_idx;
	logic in_mac, in_tpa, in_ip;
	logic want_mac, want_tpa, want_ip;
	logic cfg_m;

	assign tpa_idx = pos - frame_pkg::arp_tpa_off;
	assign ip_idx = pos - frame_pkg::ip_dst_off;

	// Field windows for the octet now on eth_in
	assign in_mac = pos < frame_pkg::src_mac_first_off;
	assign in_tpa = pos >= frame_pkg::arp_tpa_off && pos < frame_pkg::arp_tpa_off + 11'd4;
	assign in_ip = pos >= frame_pkg::ip_dst_off && pos < frame_pkg::ip_dst_off + 11'd4;

	// Memory answers next cycle, lined up with data_d1
	always_comb begin
		if (in_mac)
			cfg_a = frame_pkg::cfg_mac_base + pos[3:0];
		else if (in_tpa)
			cfg_a = frame_pkg::cfg_ip_base + tpa_idx[3:0];
		else if (in_ip)
			cfg_a = frame_pkg::cfg_ip_base + ip_idx[3:0];
		else
			cfg_a = '0;
	end

	assign cfg_m = cfg_d == data_d1;

	always_ff @(posedge clk) begin
		if (rst) begin
			want_mac <= 1'b0;
			want_tpa <= 1'b0;
			want_ip <= 1'b0;
			pass_ethmac <= 1'b0;
			pass_ipdst <= 1'b0;
			pass_arptpa <= 1'b0;
		end else begin
			// Windows delayed by one to match the memory latency
			want_mac <= in_mac;
			want_tpa <= in_tpa;
			want_ip <= in_ip;
			if (want_mac && !cfg_m) pass_ethmac <= 1'b0;
			if (want_tpa && !cfg_m) pass_arptpa <= 1'b0;
			if (want_ip && !cfg_m) pass_ipdst <= 1'b0;
			// Optimistic restart ahead of each frame
			if (pos == '0) begin
				pass_ethmac <= 1'b1;
				pass_arptpa <= 1'b1;
				pass_ipdst <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: verilog/arp_match.sv
// ##############################
// ARP request template check
// ##############################
`timescale 1ns/1ps
`default_nettype none

module arp_match (
	input  logic                      clk,
	input  logic                      rst,
	input  logic [scan_pkg::cnt_w-1:0] pos,
	input  logic [7:0]                data_d1,
	output logic                      pass
);

	logic [scan_pkg::cnt_w-1:0] hdr_idx;
	logic [7:0] template;
	logic want;

	assign hdr_idx = pos - frame_pkg::arp_hdr_off;

	// Registered so the template lines up with data_d1
	always_ff @(posedge clk) begin
		if (pos < frame_pkg::arp_hdr_off) begin
			// Ethertype, high octet first
			template <= pos[0] ? frame_pkg::ethertype_arp[7:0] : frame_pkg::ethertype_arp[15:8];
		end else begin
			case (hdr_idx[2:0])
				// Hardware type Ethernet
				3'd0: template <= 8'h00;
				3'd1: template <= 8'h01;
				// Protocol type IPv4
				3'd2: template <= frame_pkg::ethertype_ipv4[15:8];
				3'd3: template <= frame_pkg::ethertype_ipv4[7:0];
				// Hardware and protocol address lengths
				3'd4: template <= 8'h06;
				3'd5: template <= 8'h04;
				// Operation, request
				3'd6: template <= 8'h00;
				default: template <= 8'h01;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			want <= 1'b0;
			pass <= 1'b0;
		end else begin
			want <= pos >= frame_pkg::eth_type_off && pos <= frame_pkg::arp_op_end;
			if (pos == '0) pass <= 1'b1;
			if (want && data_d1 != template) pass <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: verilog/ipv4_match.sv
// ##############################
// IPv4 header check
// Template, TTL, length, checksum
// ##############################
`timescale 1ns/1ps
`default_nettype none

module ipv4_match (
	input  logic                      clk,
	input  logic                      rst,
	input  logic [scan_pkg::cnt_w-1:0] pos,
	input  logic [7:0]                data_d1,
	output logic                      pass,
	output logic [15:0]               ip_length
);

	logic [7:0] template;
	logic [7:0] cmp_mask;
	logic want, mask_df, ttl_flag;
	logic [7:0] data_d2;
	logic sum_gate, hi_byte;
	logic [15:0] sum;
	logic [15:0] addend;
	logic [16:0] sum_ext;

	// Ethertype, version/IHL, then flags and fragment offset
	always_ff @(posedge clk) begin
		if (pos == frame_pkg::ip_hdr_off)
			template <= 8'h45;
		else if (pos < frame_pkg::ip_hdr_off)
			template <= pos[0] ? frame_pkg::ethertype_ipv4[7:0] : frame_pkg::ethertype_ipv4[15:8];
		else
			template <= 8'h00;
	end

	// DF bit is allowed, any other flag or offset is a fragment
	assign cmp_mask = {1'b1, ~mask_df, 6'h3f};

	// Previous octet for the 16-bit length capture
	always_ff @(posedge clk)
		data_d2 <= data_d1;

	// One's-complement sum, even offsets are the high octet
	assign addend = hi_byte ? {data_d1, 8'h00} : {8'h00, data_d1};
	assign sum_ext = {1'b0, sum} + {1'b0, addend};

	always_ff @(posedge clk) begin
		if (pos == '0)
			sum <= '0;
		else if (sum_gate)
			sum <= sum_ext[15:0] + {15'b0, sum_ext[16]};
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			want <= 1'b0;
			mask_df <= 1'b0;
			ttl_flag <= 1'b0;
			sum_gate <= 1'b0;
			hi_byte <= 1'b0;
			ip_length <= '0;
			pass <= 1'b0;
		end else begin
			want <= (pos >= frame_pkg::eth_type_off && pos <= frame_pkg::ip_hdr_off) ||
				pos == frame_pkg::ip_hdr_off + 11'd6 || pos == frame_pkg::ip_hdr_off + 11'd7;
			mask_df <= pos == frame_pkg::ip_hdr_off + 11'd6;
			ttl_flag <= pos == frame_pkg::ip_ttl_off;
			sum_gate <= pos >= frame_pkg::ip_hdr_off && pos < frame_pkg::ip_hdr_end;
			hi_byte <= ~pos[0];
			// Total length sits in data_d2/data_d1 two positions later
			if (pos == frame_pkg::ip_len_off + 11'd2)
				ip_length <= {data_d2, data_d1};
			if (pos == '0) pass <= 1'b1;
			if (want && (data_d1 & cmp_mask) != template) pass <= 1'b0;
			// Expired packet
			if (ttl_flag && data_d1 == 8'h00) pass <= 1'b0;
			// Header sum settles one cycle after the last header octet
			if (pos == frame_pkg::ip_hdr_end + 11'd1 && sum != 16'hffff) pass <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: verilog/crc32_check.sv
// ##############################
// Ethernet CRC-32 residue check
// ##############################
`timescale 1ns/1ps
`default_nettype none

module crc32_check (
	input  logic       clk,
	input  logic       rst,
	input  logic       in_data,
	input  logic [7:0] data_d1,
	output logic       crc_ok
);

	// Reflected IEEE 802.3 polynomial
	localparam logic [31:0] crc_poly = 32'hedb88320;

	logic in_data_d1, in_data_d2;
	logic gate, first;
	logic [31:0] crc;

	// LSB-first update over one octet
	function automatic logic [31:0] crc_byte(input logic [31:0] c_in, input logic [7:0] d);
		logic [31:0] c;
		c = c_in ^ {24'h0, d};
		for (int i = 0; i < 8; i++)
			c = c[0] ? ((c >> 1) ^ crc_poly) : (c >> 1);
		return c;
	endfunction

	// data_d1 holds frame octets while in_data is high on both sides
	assign gate = in_data & in_data_d1;
	assign first = gate & ~in_data_d2;

	always_ff @(posedge clk) begin
		if (rst) begin
			in_data_d1 <= 1'b0;
			in_data_d2 <= 1'b0;
			crc <= '1;
		end else begin
			in_data_d1 <= in_data;
			in_data_d2 <= in_data_d1;
			// Preset folded into the first update
			if (gate)
				crc <= crc_byte(first ? 32'hffffffff : crc, data_d1);
		end
	end

	// FCS included, so a good frame leaves the fixed residue
	assign crc_ok = crc == frame_pkg::crc_residue;

endmodule

`default_nettype wire

// File: verilog/frame_scanner.sv
// ##############################
// Ethernet receive frame scanner
// Pipeline, summary, output stream
// ##############################
`timescale 1ns/1ps
`default_nettype none

module frame_scanner (
	input  logic        clk,
	input  logic        rst,
	input  logic [7:0]  eth_in,
	input  logic        eth_in_s,
	input  logic        eth_pkt,
	output logic [3:0]  cfg_a,
	input  logic [7:0]  cfg_d,
	output logic [7:0]  odata,
	output logic        odata_s,
	output logic        odata_f,
	output logic        status_valid,
	output logic [5:0]  status_vec,
	output logic [10:0] pack_len
);

	logic in_data, ifg_ok, too_long;
	logic [scan_pkg::cnt_w-1:0] pos;
	logic pass_ethmac, pass_ipdst, pass_arptpa;
	logic arp_ok, ipv4_ok, crc_ok;
	logic [15:0] ip_length;
	logic accept, acc_d1, acc_d2, final_octet;
	logic [7:0] data_d1, data_d2;
	logic unicast_src, ip_len_ok;
	logic pass_arp, pass_ip;
	scan_pkg::category_t category;

	rx_framer u_framer (.clk(clk), .rst(rst), .eth_in(eth_in), .eth_in_s(eth_in_s),
		.eth_pkt(eth_pkt), .ifg_ok(ifg_ok), .too_long(too_long), .in_data(in_data));

	octet_counter u_counter (.clk(clk), .rst(rst), .in_data(in_data), .pos(pos),
		.ifg_ok(ifg_ok), .too_long(too_long));

	addr_match u_addr (.clk(clk), .rst(rst), .pos(pos), .data_d1(data_d1), .cfg_d(cfg_d),
		.cfg_a(cfg_a), .pass_ethmac(pass_ethmac), .pass_ipdst(pass_ipdst),
		.pass_arptpa(pass_arptpa));

	arp_match u_arp (.clk(clk), .rst(rst), .pos(pos), .data_d1(data_d1), .pass(arp_ok));

	ipv4_match u_ipv4 (.clk(clk), .rst(rst), .pos(pos), .data_d1(data_d1), .pass(ipv4_ok),
		.ip_length(ip_length));

	crc32_check u_crc (.clk(clk), .rst(rst), .in_data(in_data), .data_d1(data_d1),
		.crc_ok(crc_ok));

	// Octet taken into the frame this cycle
	assign accept = in_data & eth_in_s & eth_pkt;

	// Two-stage data pipeline, no back-pressure
	always_ff @(posedge clk) begin
		data_d1 <= accept ? eth_in : 8'h00;
		data_d2 <= data_d1;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			acc_d1 <= 1'b0;
			acc_d2 <= 1'b0;
			unicast_src <= 1'b0;
			ip_len_ok <= 1'b0;
			pack_len <= '0;
		end else begin
			acc_d1 <= accept;
			acc_d2 <= acc_d1;
			// Group bit of the source MAC, must be clear
			if (pos == '0) unicast_src <= 1'b1;
			if (pos == frame_pkg::src_mac_first_off + 11'd1) unicast_src <= ~data_d1[0];
			if (in_data)
				ip_len_ok <= 17'(pos) >= 17'(ip_length) + 17'(frame_pkg::eth_overhead);
			// Same exit condition as the framer, held until the next frame ends
			if (in_data && (!eth_pkt || too_long))
				pack_len <= eth_pkt ? pos + 11'd1 : pos;
		end
	end

	// Last octet is on odata, nothing behind it
	assign final_octet = acc_d2 & ~acc_d1;

	assign pass_arp = unicast_src & crc_ok & arp_ok & pass_arptpa;
	assign pass_ip = unicast_src & crc_ok & pass_ethmac & ipv4_ok & pass_ipdst & ip_len_ok;
	assign category = pass_ip ? scan_pkg::cat_ipv4 :
		pass_arp ? scan_pkg::cat_arp : scan_pkg::cat_other;

	assign odata = data_d2;
	assign odata_s = acc_d2;
	assign odata_f = final_octet;
	assign status_valid = final_octet;
	assign status_vec = {pass_ip, pass_arp, pass_ethmac, crc_ok, category};

	// Summary only once the framer has closed the frame
	assert property (@(posedge clk) disable iff (rst) status_valid |-> !in_data);
	// A stream on odata always opens with octet zero of its frame
	assert property (@(posedge clk) disable iff (rst) $rose(odata_s) |-> $past(pos, 2) == '0);

endmodule

`default_nettype wire

// File: dv/frame_scanner_tb.sv
// ##############################
// Frame scanner testbench
// Table of frames, config memory model, stream and status checker
// ##############################
`timescale 1ns/1ps
`default_nettype none

module frame_scanner_tb;

	localparam int clk_period = 8;
	localparam int drain_cycles = 24;
	localparam logic [31:0] lcg_seed = 32'h11ace6d1;
	// Frame kinds
	localparam int kind_arp = 0;
	localparam int kind_ipv4 = 1;
	// Corruption codes
	localparam int corrupt_none = 0;
	localparam int wrong_mac = 1;
	localparam int ttl_zero = 2;
	localparam int bad_csum = 3;
	localparam int bad_fcs = 4;
	localparam int bad_preamble = 5;
	// Addresses of this station and of the remote sender
	localparam logic [47:0] own_mac = 48'h02_00_00_00_00_01;
	localparam logic [31:0] own_ip = 32'h0a_00_00_01;
	localparam logic [47:0] src_mac = 48'h02_00_00_00_00_0a;
	localparam logic [31:0] src_ip = 32'h0a_00_00_02;
	// IPv4 total length, 20 header octets plus 28 payload
	localparam int ip_total = 48;
	localparam int arp_frame_len = 64;
	localparam int ipv4_frame_len = 14 + ip_total + 4;

	logic clk;
	logic rst;
	logic [7:0] eth_in;
	logic eth_in_s;
	logic eth_pkt;
	logic [3:0] cfg_a;
	logic [7:0] cfg_d = 8'h00;
	logic [7:0] odata;
	logic odata_s;
	logic odata_f;
	logic status_valid;
	logic [5:0] status_vec;
	logic [10:0] pack_len;

	logic [7:0] cfg_mem [16];
	logic [31:0] lcg_state;
	logic [7:0] frame_q[$];
	// Expected stream and summaries for frames that must be accepted
	logic [7:0] sent_q[$];
	string exp_name_q[$];
	logic [5:0] exp_vec_q[$];
	int exp_len_q[$];
	logic [7:0] exp_octet;
	logic [5:0] exp_vec;
	int exp_len;
	// Stimulus table, one entry per frame
	string row_name[$];
	int row_kind[$];
	int row_corrupt[$];
	int row_pre[$];
	int row_gap[$];
	logic [5:0] row_vec[$];
	int row_len[$];

	frame_scanner u_dut (.clk(clk), .rst(rst), .eth_in(eth_in), .eth_in_s(eth_in_s),
		.eth_pkt(eth_pkt), .cfg_a(cfg_a), .cfg_d(cfg_d), .odata(odata), .odata_s(odata_s),
		.odata_f(odata_f), .status_valid(status_valid), .status_vec(status_vec),
		.pack_len(pack_len));

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	// Config memory, answers one cycle after the address
	always @(posedge clk)
		cfg_d <= cfg_mem[cfg_a];

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Done: errors found");
		$fatal(1);
	endtask

	task automatic expect_equal(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual)
			abort_run($sformatf("error %s: expected 0x%0h, actual 0x%0h", name, expected, actual));
	endtask

	function automatic logic [7:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state[23:16];
	endfunction

	// High octet first, n octets taken from the low end of v
	function automatic void push_octets(input logic [47:0] v, input int n);
		for (int i = n - 1; i >= 0; i--)
			frame_q.push_back(v[8*i +: 8]);
	endfunction

	// Internet checksum over the 20-octet IPv4 header
	function automatic logic [15:0] ip_checksum();
		logic [31:0] acc;
		acc = 32'h0;
		for (int i = 14; i < 34; i += 2)
			acc = acc + {16'h0, frame_q[i], frame_q[i + 1]};
		acc = (acc & 32'hffff) + (acc >> 16);
		acc = (acc & 32'hffff) + (acc >> 16);
		return ~acc[15:0];
	endfunction

	// Bit-serial IEEE 802.3 CRC, LSB of each octet first
	function automatic logic [31:0] frame_fcs();
		logic [31:0] c;
		logic fb;
		c = 32'hffffffff;
		foreach (frame_q[k]) begin
			for (int b = 0; b < 8; b++) begin
				fb = c[0] ^ frame_q[k][b];
				c = c >> 1;
				if (fb)
					c = c ^ 32'hedb88320;
			end
		end
		return ~c;
	endfunction

	function automatic void build_frame(input int kind, input int corrupt);
		logic [15:0] csum;
		logic [31:0] fcs;
		logic [7:0] ttl;
		frame_q.delete();
		ttl = (corrupt == ttl_zero) ? 8'h00 : 8'h40;
		if (kind == kind_arp) begin
			// Broadcast request asking for our IP
			push_octets(48'hffff_ffff_ffff, 6);
			push_octets(src_mac, 6);
			push_octets(48'h0806, 2);
			// Ethernet over IPv4, lengths 6 and 4, opcode request
			push_octets(48'h0001_0800_0604, 6);
			push_octets(48'h0001, 2);
			push_octets(src_mac, 6);
			push_octets(48'(src_ip), 4);
			push_octets(48'h0, 6);
			push_octets(48'(own_ip), 4);
			// Pad up to the minimum frame
			while (frame_q.size() < arp_frame_len - 4)
				frame_q.push_back(next_rand());
		end else begin
			push_octets((corrupt == wrong_mac) ? (own_mac ^ 48'h80) : own_mac, 6);
			push_octets(src_mac, 6);
			push_octets(48'h0800, 2);
			// Version/IHL, TOS, total length, ident
			push_octets({8'h45, 8'h00, 16'(ip_total), 16'h1234}, 6);
			// DF only, TTL, UDP, checksum filled below
			push_octets({16'h4000, ttl, 8'h11, 16'h0000}, 6);
			push_octets(48'(src_ip), 4);
			push_octets(48'(own_ip), 4);
			repeat (ip_total - 20)
				frame_q.push_back(next_rand());
			csum = ip_checksum();
			if (corrupt == bad_csum)
				csum = csum ^ 16'h0001;
			frame_q[24] = csum[15:8];
			frame_q[25] = csum[7:0];
		end
		fcs = frame_fcs();
		// FCS leaves least significant octet first
		for (int i = 0; i < 4; i++)
			frame_q.push_back(fcs[8*i +: 8]);
		if (corrupt == bad_fcs)
			frame_q[frame_q.size() - 2] = frame_q[frame_q.size() - 2] ^ 8'h20;
	endfunction

	function automatic void add_row(input string name, input int kind, input int corrupt,
		input int pre, input int gap, input logic [5:0] vec, input int len);
		row_name.push_back(name);
		row_kind.push_back(kind);
		row_corrupt.push_back(corrupt);
		row_pre.push_back(pre);
		row_gap.push_back(gap);
		row_vec.push_back(vec);
		row_len.push_back(len);
	endfunction

	// Status vector is {pass_ip, pass_arp, pass_ethmac, crc_ok, category}
	// A length of zero marks a frame the framer must drop
	function automatic void load_table();
		add_row("arp_request", kind_arp, corrupt_none, 7, 12, 6'h15, 64);
		add_row("ipv4_valid", kind_ipv4, corrupt_none, 7, 12, 6'h2e, 66);
		add_row("ipv4_wrong_mac", kind_ipv4, wrong_mac, 7, 12, 6'h04, 66);
		add_row("ipv4_ttl_zero", kind_ipv4, ttl_zero, 7, 12, 6'h0c, 66);
		add_row("ipv4_bad_csum", kind_ipv4, bad_csum, 7, 12, 6'h0c, 66);
		add_row("ipv4_bad_fcs", kind_ipv4, bad_fcs, 7, 12, 6'h08, 66);
		add_row("arp_bad_fcs", kind_arp, bad_fcs, 7, 12, 6'h00, 64);
		add_row("bad_preamble", kind_ipv4, bad_preamble, 7, 12, 6'h00, 0);
		add_row("ipv4_after_drop", kind_ipv4, corrupt_none, 7, 12, 6'h2e, 66);
		// Gap plus preamble stays under the minimum IFG
		add_row("short_gap", kind_ipv4, corrupt_none, 2, 2, 6'h00, 0);
		add_row("ipv4_after_gap", kind_ipv4, corrupt_none, 7, 12, 6'h2e, 66);
		add_row("arp_short_preamble", kind_arp, corrupt_none, 1, 12, 6'h15, 64);
	endfunction

	task automatic drive_octet(input logic [7:0] d);
		@(posedge clk);
		eth_in <= d;
		eth_in_s <= 1'b1;
		eth_pkt <= 1'b1;
	endtask

	task automatic idle_cycle();
		@(posedge clk);
		eth_in <= 8'h00;
		eth_in_s <= 1'b0;
		eth_pkt <= 1'b0;
	endtask

	task automatic send_row(input int r);
		build_frame(row_kind[r], row_corrupt[r]);
		if (row_len[r] != 0) begin
			foreach (frame_q[k])
				sent_q.push_back(frame_q[k]);
			exp_name_q.push_back(row_name[r]);
			exp_vec_q.push_back(row_vec[r]);
			exp_len_q.push_back(row_len[r]);
		end
		repeat (row_gap[r])
			idle_cycle();
		for (int p = 0; p < row_pre[r]; p++)
			drive_octet((row_corrupt[r] == bad_preamble && p == 2) ? 8'h5d : 8'h55);
		drive_octet(8'hd5);
		foreach (frame_q[k])
			drive_octet(frame_q[k]);
	endtask

	initial begin
		rst = 1'b1;
		eth_in = 8'h00;
		eth_in_s = 1'b0;
		eth_pkt = 1'b0;
		lcg_state = lcg_seed;
		// Unused entries hold a pattern of their own address
		for (int a = 0; a < 16; a++)
			cfg_mem[a] = {~a[3:0], a[3:0]};
		for (int i = 0; i < 6; i++)
			cfg_mem[i] = own_mac[8*(5 - i) +: 8];
		for (int i = 0; i < 4; i++)
			cfg_mem[8 + i] = own_ip[8*(3 - i) +: 8];
		load_table();
		repeat (5) @(posedge clk);
		rst <= 1'b0;
		for (int r = 0; r < row_name.size(); r++)
			send_row(r);
		repeat (drain_cycles)
			idle_cycle();
		if (exp_vec_q.size() != 0 || sent_q.size() != 0) begin
			abort_run("an accepted frame never completed on odata with a status");
		end else begin
			$display("Done: no errors");
			$finish;
		end
	end

	// Octets in order on odata_s, summary on status_valid
	always @(negedge clk) begin
		if (!rst && odata_s) begin
			if (sent_q.size() == 0) begin
				abort_run("odata_s raised while no accepted frame was in flight");
			end else begin
				exp_octet = sent_q.pop_front();
				expect_equal({exp_name_q[0], " odata"}, 32'(exp_octet), 32'(odata));
			end
		end
		if (!rst && status_valid) begin
			if (exp_vec_q.size() == 0) begin
				abort_run("status_valid raised for a frame that should have been dropped");
			end else begin
				exp_vec = exp_vec_q.pop_front();
				exp_len = exp_len_q.pop_front();
				expect_equal({exp_name_q[0], " status_vec"}, 32'(exp_vec), 32'(status_vec));
				expect_equal({exp_name_q[0], " pack_len"}, 32'(exp_len), 32'(pack_len));
				expect_equal({exp_name_q[0], " odata_f"}, 32'(1), 32'(odata_f));
				exp_name_q.delete(0);
			end
		end
	end

	// Budget is twice the cycles that the whole table needs
	initial begin
		int cycles;
		@(negedge rst);
		cycles = drain_cycles;
		for (int r = 0; r < row_name.size(); r++)
			cycles += row_gap[r] + row_pre[r] + 1 +
				((row_kind[r] == kind_arp) ? arp_frame_len : ipv4_frame_len);
		#(cycles * clk_period * 2);
		abort_run("watchdog expired before the frame table finished");
	end

endmodule

`default_nettype wire

// File: flist.f
verilog/frame_pkg.sv
verilog/scan_pkg.sv
verilog/rx_framer.sv
verilog/octet_counter.sv
verilog/addr_match.sv
verilog/arp_match.sv
verilog/ipv4_match.sv
verilog/crc32_check.sv
verilog/frame_scanner.sv
dv/frame_scanner_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert
TOP       := frame_scanner_tb
FLIST     := flist.f
BUILD     := obj_dir
SIM       := $(BUILD)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FLIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FLIST)

run: $(SIM)
	-./$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "Done: no errors" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
